//--- flist.f
+incdir+rtl
rtl/stcModPkg.sv
rtl/fmModRegs.sv
rtl/stcDeviationGen.sv
rtl/fmModInterpolate.sv
rtl/fmFreqScaler.sv
rtl/stcMod.sv
tests/tbClock.sv
tests/stcMod_assert.sv
tests/stcModTb.sv

//--- rtl/fmFreqScaler.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module fmFreqScaler import stcModPkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         clkEn,
    input  logic [4:0]                   cicShift,
    input  deviationReg_u                deviation,
    input  freq_t                        carrierFreq,
    input  logic signed [`STC_CIC_W-1:0] dIn,
    output sample_t                      waveform,
    output freq_t                        fmModFreq
);

    localparam int prodW = 2 * `STC_SAMPLE_W;
    localparam logic signed [`STC_CIC_W-1:0] satMax = `STC_CIC_W'((2 ** (`STC_SAMPLE_W-1)) - 1);
    localparam logic signed [`STC_CIC_W-1:0] satMin = `STC_CIC_W'(-(2 ** (`STC_SAMPLE_W-1)));

    logic signed [`STC_CIC_W-1:0] shifted;
    sample_t                      satSample;
    logic signed [prodW-1:0]      product;

    always_comb begin
        shifted = dIn >>> cicShift;
        if (shifted > satMax) begin
            satSample = sample_t'(satMax);
        end else if (shifted < satMin) begin
            satSample = sample_t'(satMin);
        end else begin
            satSample = sample_t'(shifted);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            waveform  <= '0;
            product   <= '0;
            fmModFreq <= '0;
        end else if (clkEn) begin
            waveform  <= satSample;
            product   <= waveform * $signed(deviation.fields.mantissa);
            fmModFreq <= freq_t'($signed(product[prodW-2:3]) <<< deviation.fields.exponent)
                         + carrierFreq;   // Offset is added to the carrier in the last stage
        end
    end

endmodule

//--- rtl/fmModInterpolate.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module fmModInterpolate import stcModPkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clkEn,
    input  logic                        inputClkEn,
    input  sample_t                     dIn,
    output logic signed [`STC_CIC_W-1:0] dOut
);

    localparam int order = `STC_CIC_ORDER;

    logic signed [`STC_CIC_W-1:0] combDly [order];
    logic signed [`STC_CIC_W-1:0] combStage [order+1];
    logic signed [`STC_CIC_W-1:0] combReg;
    logic                         combValid;
    logic signed [`STC_CIC_W-1:0] integ [order];
    logic signed [`STC_CIC_W-1:0] integNext [order];

    always_comb begin
        combStage[0] = `STC_CIC_W'(dIn);
        for (int k = 0; k < order; k++) begin
            combStage[k+1] = combStage[k] - combDly[k];
        end
    end

    // The comb output enters once per input sample, zeros in between
    always_comb begin
        integNext[0] = integ[0] + (combValid ? combReg : '0);
        for (int k = 1; k < order; k++) begin
            integNext[k] = integ[k] + integNext[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < order; k++) begin
                combDly[k] <= '0;
                integ[k]   <= '0;
            end
            combReg   <= '0;
            combValid <= 1'b0;
        end else if (clkEn) begin
            if (inputClkEn) begin
                for (int k = 0; k < order; k++) begin
                    combDly[k] <= combStage[k];
                end
                combReg <= combStage[order];
            end
            combValid <= inputClkEn;
            for (int k = 0; k < order; k++) begin
                integ[k] <= integNext[k];
            end
        end
    end

    assign dOut = integ[order-1];

endmodule

//--- rtl/fmModRegs.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module fmModRegs import stcModPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs,
    input  logic                    wr0,
    input  logic                    wr1,
    input  logic                    wr2,
    input  logic                    wr3,
    input  logic [`STC_ADDR_W-1:0]  addr,
    input  logic [`STC_DATA_W-1:0]  din,
    output logic [`STC_DATA_W-1:0]  dout,
    output freq_t                   carrierFreq,
    output deviationReg_u           deviation,
    output logic [15:0]             sampleDiv,
    output logic [4:0]              cicShift
);

    logic [`STC_DATA_W-1:0] carrierReg;
    deviationReg_u          devReg;
    logic [`STC_DATA_W-1:0] sampleReg;
    logic [`STC_DATA_W-1:0] rdData;
    logic [3:0]             byteWr;

    function automatic logic [`STC_DATA_W-1:0] mergeBytes(
        input logic [`STC_DATA_W-1:0] oldWord,
        input logic [`STC_DATA_W-1:0] newWord,
        input logic [3:0]             we
    );
        logic [`STC_DATA_W-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign byteWr = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk) begin
        if (reset) begin
            carrierReg <= '0;
            devReg     <= '0;
            sampleReg  <= '0;
        end else if (cs) begin
            case (addr)
                `STC_CARRIER_ADDR: carrierReg <= mergeBytes(carrierReg, din, byteWr);
                `STC_DEV_ADDR:     devReg.raw <= mergeBytes(devReg.raw, din, byteWr);
                `STC_SAMPLE_ADDR:  sampleReg  <= mergeBytes(sampleReg, din, byteWr);
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr)
            `STC_CARRIER_ADDR: rdData = carrierReg;
            `STC_DEV_ADDR:     rdData = devReg.raw;
            `STC_SAMPLE_ADDR:  rdData = sampleReg;
            default:           rdData = '0;
        endcase
    end

    assign dout        = cs ? rdData : '0;     // Bus is quiet when not selected
    assign carrierFreq = freq_t'(carrierReg);
    assign deviation   = devReg;
    assign sampleDiv   = sampleReg[15:0];
    assign cicShift    = sampleReg[20:16];

endmodule

//--- rtl/stcDeviationGen.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module stcDeviationGen import stcModPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        clkEn,
    input  logic        txEnable,
    input  logic        modData0,
    input  logic        modData1,
    input  logic        modDataValid,
    input  logic [15:0] sampleDiv,
    output logic        posEdgeModClkEn,
    output logic        devStrobe,
    output sample_t     deviation0,
    output sample_t     deviation1
);

    localparam sample_t fullScale = sample_t'((2 ** (`STC_SAMPLE_W - 1)) - 1);

    logic [15:0] sampleCount;
    logic        bitCount;
    logic        sampleEn;
    logic        firstSample;
    logic [1:0]  history0;
    logic [1:0]  history1;
    logic        signNeg;

    // Ternary SOQPSK symbol from the alternating sign, the new bit and the two previous bits
    function automatic sample_t ternary(
        input logic negSign,
        input logic cur,
        input logic prev1,
        input logic prev2
    );
        sample_t level;
        if (prev1 == prev2) begin
            level = '0;
        end else if (negSign ^ cur ^ prev1) begin
            level = -fullScale;
        end else begin
            level = fullScale;
        end
        return level;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            sampleCount     <= sampleDiv;
            bitCount        <= 1'b0;
            sampleEn        <= 1'b0;
            firstSample     <= 1'b0;
            posEdgeModClkEn <= 1'b0;
            devStrobe       <= 1'b0;
            history0        <= '0;
            history1        <= '0;
            signNeg         <= 1'b0;
            deviation0      <= '0;
            deviation1      <= '0;
        end else if (clkEn) begin
            if (sampleDiv == 16'd0) begin
                posEdgeModClkEn <= (bitCount == 1'b0);
            end else begin
                posEdgeModClkEn <= (sampleCount == 16'd1) && (bitCount == 1'b0);
            end
            if (sampleCount == 16'd0) begin
                sampleCount <= sampleDiv;
                sampleEn    <= txEnable;
                firstSample <= (bitCount == 1'b0);
                bitCount    <= ~bitCount;         // Two samples per bit
            end else begin
                sampleCount <= sampleCount - 16'd1;
                sampleEn    <= 1'b0;
            end
            devStrobe <= sampleEn && txEnable;
            if (!modDataValid) begin
                history0   <= '0;
                history1   <= '0;
                signNeg    <= 1'b0;
                deviation0 <= '0;
                deviation1 <= '0;
            end else if (sampleEn && firstSample) begin
                history0   <= {history0[0], modData0};
                history1   <= {history1[0], modData1};
                signNeg    <= ~signNeg;
                deviation0 <= ternary(signNeg, modData0, history0[0], history0[1]);
                deviation1 <= ternary(signNeg, modData1, history1[0], history1[1]);
            end
        end
    end

endmodule

//--- rtl/stcMod.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module stcMod import stcModPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clkEn,
    input  logic                    cs,
    input  logic                    wr0,
    input  logic                    wr1,
    input  logic                    wr2,
    input  logic                    wr3,
    input  logic [`STC_ADDR_W-1:0]  addr,
    input  logic [`STC_DATA_W-1:0]  din,
    output logic [`STC_DATA_W-1:0]  dout,
    input  logic                    modData0,
    input  logic                    modData1,
    input  logic                    modDataValid,
    input  logic                    txEnable,
    output logic                    posEdgeModClkEn,
    output sample_t                 modWaveform0,
    output sample_t                 modWaveform1,
    output freq_t                   fmModFreq0,
    output freq_t                   fmModFreq1
);

    freq_t                        carrierFreq;
    deviationReg_u                deviation;
    logic [15:0]                  sampleDiv;
    logic [4:0]                   cicShift;
    logic                         devStrobe;
    sample_t                      deviation0;
    sample_t                      deviation1;
    logic signed [`STC_CIC_W-1:0] cicOut0;
    logic signed [`STC_CIC_W-1:0] cicOut1;

    fmModRegs regs (
        .clk(clk), .reset(reset), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .din(din), .dout(dout),
        .carrierFreq(carrierFreq), .deviation(deviation),
        .sampleDiv(sampleDiv), .cicShift(cicShift)
    );

    stcDeviationGen devGen (
        .clk(clk), .reset(reset), .clkEn(clkEn), .txEnable(txEnable),
        .modData0(modData0), .modData1(modData1), .modDataValid(modDataValid),
        .sampleDiv(sampleDiv), .posEdgeModClkEn(posEdgeModClkEn), .devStrobe(devStrobe),
        .deviation0(deviation0), .deviation1(deviation1)
    );

    // Both filters are held clear while no valid data is present
    fmModInterpolate cic0 (
        .clk(clk), .reset(reset || !modDataValid), .clkEn(clkEn),
        .inputClkEn(devStrobe), .dIn(deviation0), .dOut(cicOut0)
    );

    fmModInterpolate cic1 (
        .clk(clk), .reset(reset || !modDataValid), .clkEn(clkEn),
        .inputClkEn(devStrobe), .dIn(deviation1), .dOut(cicOut1)
    );

    fmFreqScaler scaler0 (
        .clk(clk), .reset(reset), .clkEn(clkEn), .cicShift(cicShift),
        .deviation(deviation), .carrierFreq(carrierFreq), .dIn(cicOut0),
        .waveform(modWaveform0), .fmModFreq(fmModFreq0)
    );

    fmFreqScaler scaler1 (
        .clk(clk), .reset(reset), .clkEn(clkEn), .cicShift(cicShift),
        .deviation(deviation), .carrierFreq(carrierFreq), .dIn(cicOut1),
        .waveform(modWaveform1), .fmModFreq(fmModFreq1)
    );

endmodule

//--- rtl/stcModPkg.sv
`include "stcMod_settings.svh"

package stcModPkg;

    typedef logic signed [`STC_SAMPLE_W-1:0] sample_t;

    typedef logic signed [`STC_FREQ_W-1:0] freq_t;

    // Field layout of the deviation register
    typedef struct packed {
        logic [9:0]  spare;
        logic [3:0]  exponent;     // Left shift applied after the multiply
        logic [17:0] mantissa;     // Signed scale factor for the waveform
    } devFields_s;

    typedef union packed {
        logic [`STC_DATA_W-1:0] raw;
        devFields_s             fields;
    } deviationReg_u;

endpackage

//--- rtl/stcMod_settings.svh
`ifndef STC_MOD_SETTINGS_SVH
`define STC_MOD_SETTINGS_SVH

// Register bus
`define STC_ADDR_W          4
`define STC_DATA_W          32

// Word addresses inside the register bank
`define STC_CARRIER_ADDR    0
`define STC_DEV_ADDR        1
`define STC_SAMPLE_ADDR     2

// Datapath widths
`define STC_SAMPLE_W        18
`define STC_CIC_W           34
`define STC_FREQ_W          32

`define STC_CIC_ORDER       3

`endif

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the stcMod testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module stcModTb \
    -f flist.f -o stcModSim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/stcModSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1

//--- tests/stcModTb.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module stcModTb import stcModPkg::*; ();

    localparam int recWords = 10;
    localparam int maxTests = 8;

    logic                   clk;
    logic                   reset;
    logic                   clkEn;
    logic                   cs;
    logic                   wr0;
    logic                   wr1;
    logic                   wr2;
    logic                   wr3;
    logic [`STC_ADDR_W-1:0] addr;
    logic [`STC_DATA_W-1:0] din;
    logic [`STC_DATA_W-1:0] dout;
    logic                   modData0;
    logic                   modData1;
    logic                   modDataValid;
    logic                   txEnable;
    logic                   posEdgeModClkEn;
    sample_t                modWaveform0;
    sample_t                modWaveform1;
    freq_t                  fmModFreq0;
    freq_t                  fmModFreq1;

    logic [31:0] golden [0:maxTests*recWords];
    int          errors;
    int          failedTests;
    int          numTests;
    int          bitIdx;
    logic [31:0] pat [2];
    longint      cycles = 0;
    longint      cycleLimit = 0;

    tbClock clkGen (.clk(clk), .reset(reset));

    stcMod dut (.*);

    bind stcMod stcModAssert chk (
        .clk(clk), .reset(reset), .clkEn(clkEn), .cs(cs), .txEnable(txEnable),
        .devStrobe(devStrobe), .posEdgeModClkEn(posEdgeModClkEn),
        .sampleDiv(sampleDiv), .dout(dout)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic checkSample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkFreq(input string name, input freq_t got, input freq_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input logic [`STC_DATA_W-1:0] got,
                             input logic [`STC_DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    // Offset is bits 34 to 3 of the waveform times the mantissa, shifted left by the exponent
    function automatic freq_t scaleOffset(input sample_t w, input deviationReg_u d);
        logic signed [35:0] p;
        logic signed [31:0] mid;
        p   = 36'(w) * 36'($signed(d.fields.mantissa));
        mid = p[34:3];
        return freq_t'(mid <<< d.fields.exponent);
    endfunction

    function automatic logic patternBit(input logic [31:0] pattern, input int n);
        if (pattern == 32'd1) return 1'b1;
        if (pattern == 32'd2) return n[0];
        return 1'b0;
    endfunction

    task automatic busWrite(input int a, input logic [31:0] data, input logic [3:0] strobes);
        @(negedge clk);
        cs   = 1'b1;
        addr = `STC_ADDR_W'(a);
        din  = data;
        {wr3, wr2, wr1, wr0} = strobes;
        @(negedge clk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic busRead(input int a, output logic [31:0] data);
        @(negedge clk);
        cs   = 1'b1;
        addr = `STC_ADDR_W'(a);
        #10 data = dout;
        @(negedge clk);
        cs = 1'b0;
    endtask

    // Each byte lane goes in on its own strobe, then the word is read back
    task automatic writeReg(input int a, input logic [31:0] value);
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            busWrite(a, value, 4'(1 << b));
        end
        busRead(a, word);
        checkWord("dout", word, value);
    endtask

    task automatic nextCycle();
        @(negedge clk);
        if (clkEn && posEdgeModClkEn) begin   // Next bit for the request just seen
            bitIdx++;
            modData0 = patternBit(pat[0], bitIdx);
            modData1 = patternBit(pat[1], bitIdx);
        end
    endtask

    task automatic measureSpacing(input int div);
        int   enCount;
        int   pulses;
        int   spacing;
        int   step;
        logic enApplied;
        enCount = 0;
        pulses  = 0;
        spacing = 0;
        step    = 0;
        while (pulses < 3) begin
            clkEn     = (step % 3) != 2;    // Every third cycle is held off
            enApplied = clkEn;
            step++;
            @(negedge clk);
            if (enApplied) begin
                enCount++;
                if (posEdgeModClkEn) begin
                    pulses++;
                    if (pulses == 3) spacing = enCount;
                    enCount = 0;
                end
            end
        end
        clkEn = 1'b1;
        checkCount("posEdgeModClkEn spacing", spacing, 2 * (div + 1));
    endtask

    task automatic runTest(input int k);
        int            base;
        int            errBefore;
        freq_t         carrier;
        deviationReg_u dev;
        logic [31:0]   samp;
        sample_t       expW [2];
        freq_t         expF [2];
        sample_t       curW [2];
        freq_t         curF [2];
        sample_t       w1 [2];
        sample_t       w2 [2];
        logic          moved [2];
        base      = 1 + k * recWords;
        errBefore = errors;
        carrier   = freq_t'(golden[base]);
        dev.raw   = golden[base+1];
        samp      = golden[base+2];
        for (int ch = 0; ch < 2; ch++) begin
            pat[ch]   = golden[base+3+ch];
            expW[ch]  = sample_t'(golden[base+5+ch]);
            expF[ch]  = freq_t'(golden[base+7+ch]);
            w1[ch]    = '0;
            w2[ch]    = '0;
            moved[ch] = 1'b0;
        end
        @(negedge clk);
        modDataValid = 1'b0;
        txEnable     = 1'b0;    // No samples go out while the registers change
        writeReg(`STC_CARRIER_ADDR, carrier);
        writeReg(`STC_DEV_ADDR, dev.raw);
        writeReg(`STC_SAMPLE_ADDR, samp);
        repeat (5) @(negedge clk);
        checkSample("modWaveform0", modWaveform0, '0);
        checkSample("modWaveform1", modWaveform1, '0);
        checkFreq("fmModFreq0", fmModFreq0, carrier);
        checkFreq("fmModFreq1", fmModFreq1, carrier);
        txEnable = 1'b1;
        measureSpacing(int'(samp[15:0]));
        bitIdx       = 0;
        modData0     = patternBit(pat[0], 0);
        modData1     = patternBit(pat[1], 0);
        modDataValid = 1'b1;
        repeat (golden[base+9]) nextCycle();
        for (int i = 0; i < 64; i++) begin
            nextCycle();
            curW[0] = modWaveform0;
            curW[1] = modWaveform1;
            curF[0] = fmModFreq0;
            curF[1] = fmModFreq1;
            for (int ch = 0; ch < 2; ch++) begin
                if (pat[ch] == 32'd2) begin
                    if (curW[ch] != '0) moved[ch] = 1'b1;
                    if (i >= 2) begin
                        checkFreq($sformatf("fmModFreq%0d", ch), curF[ch],
                                  carrier + scaleOffset(w2[ch], dev));
                    end
                end else begin
                    checkSample($sformatf("modWaveform%0d", ch), curW[ch], expW[ch]);
                    checkFreq($sformatf("fmModFreq%0d", ch), curF[ch], expF[ch]);
                end
                w2[ch] = w1[ch];
                w1[ch] = curW[ch];
            end
        end
        for (int ch = 0; ch < 2; ch++) begin
            if (pat[ch] == 32'd2 && !moved[ch]) begin
                errors++;
                $display("Waveform %0d stayed at zero under an alternating pattern", ch);
            end
        end
        if (errors != errBefore) failedTests++;
        $display("Test %0d %s", k + 1, (errors == errBefore) ? "passed" : "failed");
    endtask

    initial begin
        logic [31:0] word;
        longint      limit;
        clkEn        = 1'b1;
        cs           = 1'b0;
        wr0          = 1'b0;
        wr1          = 1'b0;
        wr2          = 1'b0;
        wr3          = 1'b0;
        addr         = '0;
        din          = '0;
        modData0     = 1'b0;
        modData1     = 1'b0;
        modDataValid = 1'b0;
        txEnable     = 1'b1;
        errors       = 0;
        failedTests  = 0;
        bitIdx       = 0;
        pat[0]       = '0;
        pat[1]       = '0;
        void'($urandom(18203));
        $readmemh("tests/stcMod_golden.txt", golden);
        numTests = int'(golden[0]);
        if (numTests < 1 || numTests > maxTests) begin
            errors++;
            $display("Golden file gives no usable test count");
            numTests = 0;
        end
        limit = 2000;
        for (int k = 0; k < numTests; k++) begin
            limit += golden[2+k*recWords+8] + 200 + 24 * (golden[3+k*recWords][15:0] + 1);
        end
        cycleLimit = limit;
        @(negedge clk);
        while (reset) @(negedge clk);

        // Partial write touches byte 2 only
        writeReg(`STC_CARRIER_ADDR, 32'h12345678);
        busWrite(`STC_CARRIER_ADDR, 32'hAABBCCDD, 4'b0100);
        busRead(`STC_CARRIER_ADDR, word);
        checkWord("dout", word, 32'h12BB5678);
        $display("Test 0 %s", (errors == 0) ? "passed" : "failed");
        if (errors != 0) failedTests++;

        for (int k = 0; k < numTests; k++) begin
            repeat ($urandom_range(2, 9)) @(negedge clk);
            runTest(k);
        end

        $display("Tests run %0d, failed %0d, errors %0d", numTests + 1, failedTests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tests/stcMod_assert.sv
`timescale 1ns/1ps
`include "stcMod_settings.svh"

module stcModAssert (
    input logic                   clk,
    input logic                   reset,
    input logic                   clkEn,
    input logic                   cs,
    input logic                   txEnable,
    input logic                   devStrobe,
    input logic                   posEdgeModClkEn,
    input logic [15:0]            sampleDiv,
    input logic [`STC_DATA_W-1:0] dout
);

    // A bit request is a single enabled cycle unless the divider is zero
    pulseSingle: assert property (@(posedge clk) disable iff (reset)
        (clkEn && posEdgeModClkEn && sampleDiv != 16'd0) |=> !posEdgeModClkEn)
        else $error("posEdgeModClkEn high on two enabled cycles in a row");

    strobeGated: assert property (@(posedge clk) disable iff (reset)
        $rose(devStrobe) |-> $past(txEnable))
        else $error("devStrobe fired while txEnable was low");

    busQuiet: assert property (@(posedge clk) disable iff (reset)
        !cs |-> (dout == '0))
        else $error("dout not zero while cs is low");

endmodule

//--- tests/stcMod_golden.txt
// First word is the test count, then one test per line:
// carrier dev sample pat0 pat1 expWave0 expWave1 expFreq0 expFreq1 settleCycles
// Pattern 0 is all zeros, 1 all ones, 2 alternating (checked by the scaler rule instead)
00000005
10000000 00081000 00030003 0 1 0 0 10000000 10000000 12C
20000000 00081000 00030000 1 1 0 0 20000000 20000000 12C
30000000 00081000 00030005 0 2 0 0 30000000 30000000 190
30000000 000C1000 00030005 2 0 0 0 30000000 30000000 190
0F000000 00081000 00020003 2 2 0 0 0F000000 0F000000 190

//--- tests/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;    // Released away from the sampling edge
    end

    always #50 clk = ~clk;

endmodule
